// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_branch_unit
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== hw/branch_cmp.sv ====
/*
 * Branch comparator.
 * Resolves the six conditional branches and jumps, and adds the target operands.
 */

`include "rvc_params.svh"

module branch_cmp (
	input  rvc_pkg::branch_op_t     op_i,
	input  logic [`RVC_DATA_W-1:0]  rs1_i,
	input  logic [`RVC_DATA_W-1:0]  rs2_i,
	input  logic [`RVC_ADDR_W-1:0]  num1_i,
	input  logic [`RVC_ADDR_W-1:0]  num2_i,
	output logic                    taken_o,
	output logic [`RVC_ADDR_W-1:0]  target_o
);

	import rvc_pkg::*;

	logic eq;
	logic lt_s;
	logic lt_u;

	assign eq   = (rs1_i == rs2_i);
	assign lt_s = ($signed(rs1_i) < $signed(rs2_i));
	assign lt_u = (rs1_i < rs2_i);

	always_comb begin
		case (op_i)
			BR_BEQ:  taken_o = eq;
			BR_BNE:  taken_o = !eq;
			BR_BLT:  taken_o = lt_s;
			BR_BGE:  taken_o = !lt_s;
			BR_BLTU: taken_o = lt_u;
			BR_BGEU: taken_o = !lt_u;
			BR_JUMP: taken_o = 1'b1;
			default: taken_o = 1'b0; // BR_NONE.
		endcase
	end

	// Base plus offset for both branches and jumps.
	assign target_o = num1_i + num2_i;

endmodule

// ==== hw/branch_unit_top.sv ====
/*
 * Branch resolution and redirect unit.
 * Comparator, redirect controller and BTB of the execute stage.
 */

`include "rvc_params.svh"

module branch_unit_top (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    stall_i,
	input  logic                    load_hazard_i,
	input  rvc_pkg::branch_op_t     op_i,
	input  logic [`RVC_DATA_W-1:0]  rs1_i,
	input  logic [`RVC_DATA_W-1:0]  rs2_i,
	input  logic [`RVC_ADDR_W-1:0]  num1_i,
	input  logic [`RVC_ADDR_W-1:0]  num2_i,
	input  logic [`RVC_ADDR_W-1:0]  pc_fetch_i,
	input  logic [`RVC_ADDR_W-1:0]  pc_instr_i,
	output logic                    jmp_en_o,
	output logic [`RVC_ADDR_W-1:0]  jmp_to_o,
	output logic                    instr_mask_o,
	output rvc_pkg::hold_code_t     hold_code_o
);

	logic                   resolved_taken;
	logic [`RVC_ADDR_W-1:0] resolved_target;

	btb_if btb_bus ();

	branch_cmp branch_cmp_inst (
		.op_i     (op_i),
		.rs1_i    (rs1_i),
		.rs2_i    (rs2_i),
		.num1_i   (num1_i),
		.num2_i   (num2_i),
		.taken_o  (resolved_taken),
		.target_o (resolved_target)
	);

	redirect_ctrl redirect_ctrl_inst (
		.clk               (clk),
		.reset_i           (reset_i),
		.stall_i           (stall_i),
		.load_hazard_i     (load_hazard_i),
		.op_i              (op_i),
		.pc_fetch_i        (pc_fetch_i),
		.pc_instr_i        (pc_instr_i),
		.resolved_taken_i  (resolved_taken),
		.resolved_target_i (resolved_target),
		.bus               (btb_bus.ctrl),
		.jmp_en_o          (jmp_en_o),
		.jmp_to_o          (jmp_to_o),
		.instr_mask_o      (instr_mask_o),
		.hold_code_o       (hold_code_o)
	);

	btb #(
		.ENTRIES (`RVC_BTB_ENTRIES)
	) btb_inst (
		.clk     (clk),
		.reset_i (reset_i),
		.bus     (btb_bus.buffer)
	);

endmodule

// ==== hw/btb.sv ====
/*
 * Branch target buffer.
 * Direct-mapped, tagged, with a 2-bit saturating counter per entry.
 * Two combinational read ports (fetch and check) and one write port.
 */

`include "rvc_params.svh"

module btb #(
	parameter int ENTRIES = `RVC_BTB_ENTRIES
) (
	input  logic  clk,
	input  logic  reset_i,
	btb_if.buffer bus
);

	import rvc_pkg::*;

	localparam int ADDR_W = `RVC_ADDR_W;
	localparam int IDX_W  = $clog2(ENTRIES);
	localparam int TAG_W  = ADDR_W - IDX_W - 2;

	logic [ENTRIES-1:0] valid_q;
	logic [TAG_W-1:0]   tag_q    [ENTRIES];
	logic [ADDR_W-1:0]  target_q [ENTRIES];
	ctr_state_t         ctr_q    [ENTRIES];

	logic [IDX_W-1:0] fetch_idx;
	logic [TAG_W-1:0] fetch_tag;
	logic [IDX_W-1:0] chk_idx;
	logic [TAG_W-1:0] chk_tag;
	logic [IDX_W-1:0] upd_idx;
	logic [TAG_W-1:0] upd_tag;
	logic             upd_hit;

	function automatic ctr_state_t ctr_next(input ctr_state_t cur, input logic taken);
		ctr_state_t nxt;
		case (cur)
			STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
			WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
			WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
			default:   nxt = taken ? STRONG_T : WEAK_T;
		endcase
		return nxt;
	endfunction

	// Word-aligned PCs, so bits [1:0] are skipped.
	assign fetch_idx = bus.fetch_pc[IDX_W+1:2];
	assign fetch_tag = bus.fetch_pc[ADDR_W-1:IDX_W+2];
	assign chk_idx   = bus.check_pc[IDX_W+1:2];
	assign chk_tag   = bus.check_pc[ADDR_W-1:IDX_W+2];
	assign upd_idx   = bus.upd_pc[IDX_W+1:2];
	assign upd_tag   = bus.upd_pc[ADDR_W-1:IDX_W+2];

	assign bus.pred_taken  = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag) &&
				 (ctr_q[fetch_idx] inside {WEAK_T, STRONG_T});
	assign bus.pred_target = target_q[fetch_idx];

	assign bus.chk_taken   = valid_q[chk_idx] && (tag_q[chk_idx] == chk_tag) &&
				 (ctr_q[chk_idx] inside {WEAK_T, STRONG_T});
	assign bus.chk_target  = target_q[chk_idx];

	assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= '0;
		end else if (bus.upd_en && bus.upd_taken && !upd_hit) begin
			valid_q[upd_idx] <= 1'b1; // Allocate on a taken miss.
		end
	end

	always_ff @(posedge clk) begin
		if (bus.upd_en) begin
			if (upd_hit) begin
				ctr_q[upd_idx] <= ctr_next(ctr_q[upd_idx], bus.upd_taken);
				if (bus.upd_taken) begin
					target_q[upd_idx] <= bus.upd_target;
				end
			end else if (bus.upd_taken) begin
				tag_q[upd_idx]    <= upd_tag; // Replaces any alias.
				target_q[upd_idx] <= bus.upd_target;
				ctr_q[upd_idx]    <= ctr_state_t'(`RVC_CTR_INIT);
			end
		end
	end

	// The controller must only train taken targets that fetch can use.
	a_upd_target_aligned: assert property (
		@(posedge clk) disable iff (reset_i)
		(bus.upd_en && bus.upd_taken) |-> (bus.upd_target[1:0] == 2'b00)
	) else $error("btb: unaligned taken target %h", bus.upd_target);

endmodule

// ==== hw/btb_if.sv ====
/*
 * BTB port bundle.
 * Fetch lookup, check lookup and update between the redirect controller and the BTB.
 */

`include "rvc_params.svh"

interface btb_if;

	logic [`RVC_ADDR_W-1:0] fetch_pc;    // PC being fetched.
	logic [`RVC_ADDR_W-1:0] check_pc;    // PC of the branch in execute.
	logic                   upd_en;
	logic [`RVC_ADDR_W-1:0] upd_pc;
	logic                   upd_taken;
	logic [`RVC_ADDR_W-1:0] upd_target;

	logic                   pred_taken;
	logic [`RVC_ADDR_W-1:0] pred_target;
	logic                   chk_taken;
	logic [`RVC_ADDR_W-1:0] chk_target;

	modport ctrl (
		output fetch_pc, check_pc, upd_en, upd_pc, upd_taken, upd_target,
		input  pred_taken, pred_target, chk_taken, chk_target
	);

	modport buffer (
		input  fetch_pc, check_pc, upd_en, upd_pc, upd_taken, upd_target,
		output pred_taken, pred_target, chk_taken, chk_target
	);

endinterface

// ==== hw/redirect_ctrl.sv ====
/*
 * Redirect controller.
 * Checks each resolved branch against its BTB prediction, issues the fetch
 * redirect, registers the mispredict mask and encodes the pipeline hold code.
 */

`include "rvc_params.svh"

module redirect_ctrl (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    stall_i,
	input  logic                    load_hazard_i,
	input  rvc_pkg::branch_op_t     op_i,
	input  logic [`RVC_ADDR_W-1:0]  pc_fetch_i,
	input  logic [`RVC_ADDR_W-1:0]  pc_instr_i,
	input  logic                    resolved_taken_i,
	input  logic [`RVC_ADDR_W-1:0]  resolved_target_i,
	btb_if.ctrl                     bus,
	output logic                    jmp_en_o,
	output logic [`RVC_ADDR_W-1:0]  jmp_to_o,
	output logic                    instr_mask_o,
	output rvc_pkg::hold_code_t     hold_code_o
);

	import rvc_pkg::*;

	localparam logic [`RVC_ADDR_W-1:0] STEP = `RVC_INSTR_STEP;

	logic branch_active;
	logic mispredict;
	logic mask_q;

	assign branch_active = (op_i != BR_NONE) && !stall_i && !load_hazard_i;

	// Wrong direction, or taken to a stale target.
	assign mispredict = branch_active &&
			    ((resolved_taken_i != bus.chk_taken) ||
			     (resolved_taken_i && (resolved_target_i != bus.chk_target)));

	always_comb begin
		if (mispredict) begin
			jmp_en_o = 1'b1;
			jmp_to_o = resolved_taken_i ? resolved_target_i : (pc_instr_i + STEP);
		end else begin
			jmp_en_o = bus.pred_taken;
			jmp_to_o = bus.pred_taken ? bus.pred_target : '0;
		end
	end

	always_comb begin
		if (stall_i) begin
			hold_code_o = HOLD_EX;
		end else if (load_hazard_i) begin
			hold_code_o = HOLD_ID;
		end else begin
			hold_code_o = HOLD_NONE;
		end
	end

	// Kills the wrong-path instruction one cycle later.
	always_ff @(posedge clk) begin
		if (reset_i) begin
			mask_q <= 1'b0;
		end else begin
			mask_q <= mispredict;
		end
	end

	assign instr_mask_o = mask_q;

	assign bus.fetch_pc   = pc_fetch_i;
	assign bus.check_pc   = pc_instr_i;
	assign bus.upd_en     = branch_active;
	assign bus.upd_pc     = pc_instr_i;
	assign bus.upd_taken  = resolved_taken_i;
	assign bus.upd_target = resolved_target_i;

	// Fetch only ever restarts on a word boundary.
	a_redirect_aligned: assert property (
		@(posedge clk) disable iff (reset_i)
		jmp_en_o |-> (jmp_to_o[1:0] == 2'b00)
	) else $error("redirect_ctrl: unaligned redirect to %h", jmp_to_o);

endmodule

// ==== hw/rvc_params.svh ====
/*
 * Branch unit parameters.
 * Widths, BTB depth, the fall-through step and the counter value of a new entry.
 */

`ifndef RVC_PARAMS_SVH
`define RVC_PARAMS_SVH

// Program counter and jump target width.
`define RVC_ADDR_W 32

// Register operand width.
`define RVC_DATA_W 32

// Default number of BTB entries, a power of two.
`define RVC_BTB_ENTRIES 16

// PC increment of a not-taken branch.
`define RVC_INSTR_STEP 4

// Counter state of a freshly allocated BTB entry, weakly taken.
`define RVC_CTR_INIT 2'b10

`endif

// ==== hw/rvc_pkg.sv ====
/*
 * Branch unit types.
 * Jump opcodes, pipeline hold codes and the BTB counter states.
 */

package rvc_pkg;

	// Jump flags from decode.
	typedef enum logic [3:0] {
		BR_NONE = 4'd0,
		BR_BEQ  = 4'd1,
		BR_BNE  = 4'd2,
		BR_BLT  = 4'd3,
		BR_BGE  = 4'd4,
		BR_BLTU = 4'd5,
		BR_BGEU = 4'd6,
		BR_JUMP = 4'd7
	} branch_op_t;

	// How far back the pipeline is frozen.
	typedef enum logic [1:0] {
		HOLD_NONE = 2'b00,
		HOLD_ID   = 2'b01, // Fetch and decode held.
		HOLD_EX   = 2'b10  // Up to execute held.
	} hold_code_t;

	// Two-bit saturating counter, upper bit is the prediction.
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} ctr_state_t;

endpackage

// ==== sim/branch_unit_tasks.svh ====
/*
 * Branch unit testbench helpers.
 * Reference BTB model, the cycle drive task and the typed compare tasks.
 */

`ifndef BRANCH_UNIT_TASKS_SVH
`define BRANCH_UNIT_TASKS_SVH

localparam int N_ENT = `RVC_BTB_ENTRIES;

logic                   m_valid  [N_ENT];
logic [`RVC_ADDR_W-1:0] m_tag    [N_ENT];
logic [`RVC_ADDR_W-1:0] m_target [N_ENT];
ctr_state_t             m_ctr    [N_ENT];
int unsigned            checks = 0;
int unsigned            errors = 0;
logic                   last_misp; // Model mispredict of the previous cycle.

task automatic check_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic check_addr(input string name, input logic [`RVC_ADDR_W-1:0] got,
		input logic [`RVC_ADDR_W-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic check_hold(input string name, input hold_code_t got, input hold_code_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
	end
endtask

// Entry number and tag of a word address.
function automatic int unsigned slot(input logic [`RVC_ADDR_W-1:0] pc);
	return (pc / 4) % N_ENT;
endfunction

function automatic logic [`RVC_ADDR_W-1:0] tag_of(input logic [`RVC_ADDR_W-1:0] pc);
	return pc / (4 * N_ENT);
endfunction

function automatic logic model_hit(input logic [`RVC_ADDR_W-1:0] pc);
	int unsigned i;
	i = slot(pc);
	return m_valid[i] && (m_tag[i] == tag_of(pc)) && (m_ctr[i] >= WEAK_T);
endfunction

function automatic void model_train(input logic [`RVC_ADDR_W-1:0] pc, input logic taken,
		input logic [`RVC_ADDR_W-1:0] target);
	int unsigned i;
	i = slot(pc);
	if (m_valid[i] && (m_tag[i] == tag_of(pc))) begin
		if (taken && m_ctr[i] != STRONG_T)
			m_ctr[i] = ctr_state_t'(m_ctr[i] + 2'd1);
		else if (!taken && m_ctr[i] != STRONG_NT)
			m_ctr[i] = ctr_state_t'(m_ctr[i] - 2'd1);
		if (taken)
			m_target[i] = target;
	end else if (taken) begin
		m_valid[i]  = 1'b1; // New entry starts weakly taken.
		m_tag[i]    = tag_of(pc);
		m_target[i] = target;
		m_ctr[i]    = WEAK_T;
	end
endfunction

function automatic logic branch_taken(input branch_op_t op, input logic [`RVC_DATA_W-1:0] a,
		input logic [`RVC_DATA_W-1:0] b);
	case (op)
		BR_BEQ:  return a == b;
		BR_BNE:  return a != b;
		BR_BLT:  return $signed(a) < $signed(b);
		BR_BGE:  return $signed(a) >= $signed(b);
		BR_BLTU: return a < b;
		BR_BGEU: return a >= b;
		BR_JUMP: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// One clock cycle: drive on the falling edge, check mid-cycle, then train the model.
task automatic drive_cycle(input branch_op_t op, input logic [`RVC_DATA_W-1:0] a,
		input logic [`RVC_DATA_W-1:0] b, input logic [`RVC_ADDR_W-1:0] base,
		input logic [`RVC_ADDR_W-1:0] offs, input logic [`RVC_ADDR_W-1:0] pcf,
		input logic [`RVC_ADDR_W-1:0] pci, input logic stall, input logic lhaz);
	logic                   active;
	logic                   taken;
	logic [`RVC_ADDR_W-1:0] target;
	logic                   misp;
	logic [`RVC_ADDR_W-1:0] exp_to;
	wait_fall();
	op_i          = op;
	rs1_i         = a;
	rs2_i         = b;
	num1_i        = base;
	num2_i        = offs;
	pc_fetch_i    = pcf;
	pc_instr_i    = pci;
	stall_i       = stall;
	load_hazard_i = lhaz;
	active = (op != BR_NONE) && !stall && !lhaz;
	taken  = branch_taken(op, a, b);
	target = base + offs;
	misp   = active && ((taken != model_hit(pci)) ||
			(taken && (target != m_target[slot(pci)])));
	if (misp)
		exp_to = taken ? target : pci + `RVC_INSTR_STEP;
	else
		exp_to = model_hit(pcf) ? m_target[slot(pcf)] : '0;
	#10;
	check_bit("instr_mask_o", instr_mask_o, last_misp);
	check_bit("jmp_en_o", jmp_en_o, misp || model_hit(pcf));
	check_addr("jmp_to_o", jmp_to_o, exp_to);
	check_hold("hold_code_o", hold_code_o, stall ? HOLD_EX : (lhaz ? HOLD_ID : HOLD_NONE));
	if (active)
		model_train(pci, taken, target);
	last_misp = misp;
endtask

`endif

// ==== sim/tb_branch_unit.sv ====
/*
 * Branch unit testbench.
 * Directed tests of resolution, BTB training, hazards, the mask and aliasing.
 */

`include "rvc_params.svh"

module tb_branch_unit;

	timeunit 1ns;
	timeprecision 100ps;

	import rvc_pkg::*;

	localparam logic [`RVC_ADDR_W-1:0] FAR_PC   = 32'hffff_ff00; // Never trained.
	localparam logic [`RVC_ADDR_W-1:0] TRAIN_PC = 32'h0000_2040;
	localparam logic [`RVC_ADDR_W-1:0] HAZ_PC   = 32'h0000_4000;
	localparam logic [`RVC_ADDR_W-1:0] ALIAS_A  = 32'h0000_5008;
	localparam logic [`RVC_ADDR_W-1:0] ALIAS_B  = 32'h0000_5048; // Same entry, other tag.

	logic                   clk;
	logic                   reset_i;
	logic                   stall_i;
	logic                   load_hazard_i;
	branch_op_t             op_i;
	logic [`RVC_DATA_W-1:0] rs1_i;
	logic [`RVC_DATA_W-1:0] rs2_i;
	logic [`RVC_ADDR_W-1:0] num1_i;
	logic [`RVC_ADDR_W-1:0] num2_i;
	logic [`RVC_ADDR_W-1:0] pc_fetch_i;
	logic [`RVC_ADDR_W-1:0] pc_instr_i;
	logic                   jmp_en_o;
	logic [`RVC_ADDR_W-1:0] jmp_to_o;
	logic                   instr_mask_o;
	hold_code_t             hold_code_o;
	int                     seed = 32'hc8d4_d9d6;
	int unsigned            test_errors = 0;

	`include "branch_unit_tasks.svh"

	branch_unit_top branch_unit_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic wait_level(input logic level);
		int polls;
		polls = 0;
		while (clk !== level && polls < 1000) begin
			#0.1;
			polls++;
		end
		if (clk !== level) begin
			$display("Timeout: the clock stopped toggling.");
			$display("TEST FAIL");
			$finish;
		end
	endtask

	task automatic wait_fall();
		wait_level(1'b1);
		wait_level(1'b0);
	endtask

	task automatic report_test(input string name);
		$display("%s: %0d error(s)", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic apply_reset();
		reset_i = 1'b1;
		for (int i = 0; i < N_ENT; i++)
			m_valid[i] = 1'b0;
		last_misp = 1'b0;
		repeat (3) wait_fall();
		reset_i = 1'b0;
		#10;
		check_bit("instr_mask_o", instr_mask_o, 1'b0);
	endtask

	task automatic test_cold();
		logic [`RVC_DATA_W-1:0] a;
		logic [`RVC_DATA_W-1:0] b;
		for (int k = 0; k < 32; k++) begin
			a = $random(seed);
			// Equal or sign-flipped operands now and then.
			b = (k % 4 == 0) ? a : ((k % 4 == 1) ? ~a : $random(seed));
			drive_cycle(branch_op_t'(4'(k / 4)), a, b, $random(seed) & 32'hffff_fffc,
				$random(seed) & 32'hffff_fffc, FAR_PC, 32'h0001_0000 + 4 * k, 1'b0, 1'b0);
		end
		report_test("cold_btb");
	endtask

	task automatic test_training();
		for (int p = 0; p < 4; p++)
			drive_cycle(BR_BEQ, 32'h5, 32'h5, 32'h0000_3000, 32'h0000_0040,
				(p == 0) ? FAR_PC : TRAIN_PC, TRAIN_PC, 1'b0, 1'b0);
		report_test("training");
	endtask

	task automatic test_reversal();
		drive_cycle(BR_BNE, 32'h7, 32'h7, 32'h0000_3000, 32'h0000_0040, FAR_PC, TRAIN_PC, 0, 0);
		drive_cycle(BR_NONE, 0, 0, 0, 0, TRAIN_PC, FAR_PC, 0, 0);
		drive_cycle(BR_JUMP, 0, 0, 32'h0000_3800, 32'h0000_0020, FAR_PC, TRAIN_PC, 0, 0);
		drive_cycle(BR_NONE, 0, 0, 0, 0, TRAIN_PC, FAR_PC, 0, 0);
		report_test("reversal");
	endtask

	task automatic test_hazards();
		drive_cycle(BR_JUMP, 0, 0, 32'h0000_6000, 0, FAR_PC, HAZ_PC, 1'b0, 1'b1);
		drive_cycle(BR_JUMP, 0, 0, 32'h0000_6000, 0, FAR_PC, HAZ_PC, 1'b1, 1'b0);
		drive_cycle(BR_JUMP, 0, 0, 32'h0000_6000, 0, FAR_PC, HAZ_PC, 1'b1, 1'b1);
		drive_cycle(BR_NONE, 0, 0, 0, 0, HAZ_PC, FAR_PC, 1'b0, 1'b0);
		report_test("hazards");
	endtask

	task automatic test_mask();
		logic [`RVC_ADDR_W-1:0] pc;
		for (int k = 0; k < 16; k++) begin
			pc = 32'h0000_7000 + 4 * ($random(seed) & 3);
			drive_cycle(branch_op_t'(4'($random(seed) & 7)), $random(seed) & 1,
				$random(seed) & 1, 32'h0000_7100, 32'h0000_0010, pc, pc, 1'b0, 1'b0);
		end
		report_test("mask");
	endtask

	task automatic test_aliasing();
		drive_cycle(BR_JUMP, 0, 0, 32'h0000_9000, 0, FAR_PC, ALIAS_A, 0, 0);
		drive_cycle(BR_JUMP, 0, 0, 32'h0000_9000, 0, ALIAS_A, ALIAS_A, 0, 0);
		drive_cycle(BR_NONE, 0, 0, 0, 0, ALIAS_B, FAR_PC, 0, 0);
		drive_cycle(BR_JUMP, 0, 0, 32'h0000_9400, 0, ALIAS_B, ALIAS_B, 0, 0);
		drive_cycle(BR_NONE, 0, 0, 0, 0, ALIAS_B, FAR_PC, 0, 0);
		drive_cycle(BR_NONE, 0, 0, 0, 0, ALIAS_A, FAR_PC, 0, 0);
		report_test("aliasing");
	endtask

	initial begin
		reset_i       = 1'b1;
		stall_i       = 1'b0;
		load_hazard_i = 1'b0;
		op_i          = BR_NONE;
		rs1_i         = '0;
		rs2_i         = '0;
		num1_i        = '0;
		num2_i        = '0;
		pc_fetch_i    = '0;
		pc_instr_i    = '0;
		apply_reset();
		test_cold();
		test_training();
		test_reversal();
		test_hazards();
		test_mask();
		test_aliasing();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+hw
+incdir+sim
hw/rvc_pkg.sv
hw/btb_if.sv
hw/branch_cmp.sv
hw/btb.sv
hw/redirect_ctrl.sv
hw/branch_unit_top.sv
sim/tb_branch_unit.sv
